//--- include/display_defaults.svh
`ifndef DISPLAY_DEFAULTS_SVH
`define DISPLAY_DEFAULTS_SVH

// default frame geometry.
`define DISPLAY_PIXEL_WIDTH     8
`define DISPLAY_PIXEL_HEIGHT    4
`define DISPLAY_BYTES_PER_PIXEL 2

`endif

//--- design/display_pkg.sv
package display_pkg;

    // fixed field widths of the RAM write bundle.
    localparam int MAX_ROW_BITS = 8;
    localparam int MAX_COL_BITS = 8;
    localparam int MAX_BYTE_BITS = 8;
    localparam int PIX_PORT_BITS = 32; // pixel output port, unused high bytes are zero.

    typedef enum logic [7:0] {
        CMD_WRITE_ROW = 8'd1,
        CMD_FILL      = 8'd2,
        CMD_SCAN      = 8'd3
    } display_opcode_e;

    typedef enum logic [2:0] {
        DEC_IDLE,
        DEC_WRITE_ROW,
        DEC_FILL_VALUE,
        DEC_FILL_RUN,
        DEC_SCAN_WAIT
    } decoder_state_e;

    typedef enum logic [1:0] {
        ROW_CAPTURE,
        ROW_PRIME,
        ROW_CONTENT
    } writer_state_e;

    typedef enum logic [1:0] {
        SCAN_IDLE,
        SCAN_READ,
        SCAN_PRESENT
    } scan_state_e;

    typedef struct packed {
        logic [MAX_ROW_BITS-1:0]  row;
        logic [MAX_COL_BITS-1:0]  column;
        logic [MAX_BYTE_BITS-1:0] byte_idx;
        logic [7:0]               data;
        logic                     strobe;
    } ram_write_t;

    typedef struct packed {
        logic [PIX_PORT_BITS-1:0] data;
        logic                     last;
    } pixel_t;

    // at least one bit, even for a count of one.
    function automatic int bits_for(input int count);
        return (count > 1) ? $clog2(count) : 1;
    endfunction

    function automatic int frame_bytes(input int width, input int height, input int bpp);
        return width * height * bpp;
    endfunction

endpackage

//--- design/cmd_decoder.sv
module cmd_decoder import display_pkg::*; #(
    parameter int PIXEL_WIDTH,
    parameter int PIXEL_HEIGHT,
    parameter int BYTES_PER_PIXEL
) (
    input  logic       clk_n,
    input  logic       reset,
    input  logic [7:0] byte_data,
    input  logic       byte_valid,
    output logic       byte_ready,
    output logic       writer_enable,
    input  logic       writer_done,
    input  ram_write_t writer_port,
    output ram_write_t ram_port,
    output logic       scan_start,
    input  logic       scan_busy
);
    localparam int ROW_BITS = bits_for(PIXEL_HEIGHT);
    localparam int COL_BITS = bits_for(PIXEL_WIDTH);
    localparam int BYTE_BITS = bits_for(BYTES_PER_PIXEL);
    localparam int ROW_BYTES = PIXEL_WIDTH * BYTES_PER_PIXEL + 1; // row byte plus data.
    localparam int LEFT_BITS = bits_for(ROW_BYTES + 1);

    decoder_state_e state;
    logic accept;
    logic [LEFT_BITS-1:0] row_left;
    logic [ROW_BITS-1:0] fill_row;
    logic [COL_BITS-1:0] fill_col;
    logic [BYTE_BITS-1:0] fill_byte;
    logic [7:0] fill_value;
    logic fill_last;
    ram_write_t fill_port;

    always_comb begin
        case (state)
            DEC_IDLE, DEC_FILL_VALUE: byte_ready = 1'b1;
            DEC_WRITE_ROW: byte_ready = (row_left != '0); // closed once the row is in.
            default: byte_ready = 1'b0;
        endcase
    end

    assign accept = byte_valid && byte_ready;
    assign writer_enable = accept && (state == DEC_WRITE_ROW);

    assign fill_last = (fill_row == ROW_BITS'(PIXEL_HEIGHT - 1)) &&
                       (fill_col == COL_BITS'(PIXEL_WIDTH - 1)) &&
                       (fill_byte == BYTE_BITS'(BYTES_PER_PIXEL - 1));

    always_comb begin
        fill_port = '0;
        fill_port.row = MAX_ROW_BITS'(fill_row);
        fill_port.column = MAX_COL_BITS'(fill_col);
        fill_port.byte_idx = MAX_BYTE_BITS'(fill_byte);
        fill_port.data = fill_value;
        fill_port.strobe = 1'b1;
    end

    assign ram_port = (state == DEC_FILL_RUN) ? fill_port : writer_port;

    always_ff @(posedge clk_n) begin
        if (reset) begin
            state <= DEC_IDLE;
            scan_start <= 1'b0;
            row_left <= '0;
            fill_row <= '0;
            fill_col <= '0;
            fill_byte <= '0;
        end else begin
            scan_start <= 1'b0;
            case (state)
                DEC_IDLE: begin
                    if (accept) begin
                        case (display_opcode_e'(byte_data))
                            CMD_WRITE_ROW: begin
                                state <= DEC_WRITE_ROW;
                                row_left <= LEFT_BITS'(ROW_BYTES);
                            end
                            CMD_FILL: state <= DEC_FILL_VALUE;
                            CMD_SCAN: begin
                                state <= DEC_SCAN_WAIT;
                                scan_start <= 1'b1;
                            end
                            default: state <= DEC_IDLE; // unknown opcode, dropped.
                        endcase
                    end
                end
                DEC_WRITE_ROW: begin
                    if (writer_enable) row_left <= row_left - 1'b1;
                    if (writer_done) state <= DEC_IDLE;
                end
                DEC_FILL_VALUE: begin
                    if (accept) begin
                        fill_row <= '0;
                        fill_col <= '0;
                        fill_byte <= '0;
                        state <= DEC_FILL_RUN;
                    end
                end
                DEC_FILL_RUN: begin
                    if (fill_byte != BYTE_BITS'(BYTES_PER_PIXEL - 1)) begin
                        fill_byte <= fill_byte + 1'b1;
                    end else begin
                        fill_byte <= '0;
                        if (fill_col != COL_BITS'(PIXEL_WIDTH - 1)) begin
                            fill_col <= fill_col + 1'b1;
                        end else begin
                            fill_col <= '0;
                            fill_row <= fill_row + 1'b1;
                        end
                    end
                    if (fill_last) state <= DEC_IDLE;
                end
                DEC_SCAN_WAIT: begin
                    // busy rises one cycle after the start pulse.
                    if (!scan_start && !scan_busy) state <= DEC_IDLE;
                end
                default: state <= DEC_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_n) begin
        if (state == DEC_FILL_VALUE && accept) fill_value <= byte_data;
    end

    // ready stays low through the run and returns right after the last fill write.
    a_no_ready_in_fill: assert property (@(posedge clk_n) disable iff (reset)
        (state == DEC_FILL_RUN) |=> (byte_ready == $past(fill_last)));

endmodule

//--- design/row_writer.sv
module row_writer import display_pkg::*; #(
    parameter int PIXEL_WIDTH,
    parameter int PIXEL_HEIGHT,
    parameter int BYTES_PER_PIXEL
) (
    input  logic       clk_n,
    input  logic       reset,
    input  logic       enable,
    input  logic [7:0] data_in,
    output ram_write_t ram_port,
    output logic       done
);
    localparam int ROW_BITS = bits_for(PIXEL_HEIGHT);
    localparam int COL_BITS = bits_for(PIXEL_WIDTH);
    localparam int BYTE_BITS = bits_for(BYTES_PER_PIXEL);
    localparam logic [COL_BITS-1:0] LAST_COL = COL_BITS'(PIXEL_WIDTH - 1);
    localparam logic [BYTE_BITS-1:0] LAST_BYTE = BYTE_BITS'(BYTES_PER_PIXEL - 1);

    writer_state_e state;
    logic [ROW_BITS-1:0] row;
    logic [COL_BITS-1:0] column;
    logic [BYTE_BITS-1:0] byte_idx;
    logic [COL_BITS-1:0] next_column;
    logic [BYTE_BITS-1:0] next_byte;
    logic [7:0] data_q;
    logic strobe;

    // byte index counts down and borrows from the column.
    always_comb begin
        if (byte_idx == '0) begin
            next_byte = LAST_BYTE;
            next_column = column - 1'b1;
        end else begin
            next_byte = byte_idx - 1'b1;
            next_column = column;
        end
    end

    always_ff @(posedge clk_n) begin
        if (reset) begin
            state <= ROW_CAPTURE;
            row <= '0;
            column <= '0;
            byte_idx <= '0;
            strobe <= 1'b0;
            done <= 1'b0;
        end else begin
            strobe <= 1'b0;
            done <= strobe && (column == '0) && (byte_idx == '0); // after the final write.
            case (state)
                ROW_CAPTURE: begin
                    if (enable) begin
                        row <= data_in[ROW_BITS-1:0]; // row wraps by its low bits.
                        state <= ROW_PRIME;
                    end
                end
                ROW_PRIME: begin
                    if (enable) begin
                        column <= LAST_COL;
                        byte_idx <= LAST_BYTE;
                        strobe <= 1'b1;
                        if (LAST_COL == '0 && LAST_BYTE == '0) state <= ROW_CAPTURE;
                        else state <= ROW_CONTENT;
                    end
                end
                ROW_CONTENT: begin
                    if (enable) begin
                        column <= next_column;
                        byte_idx <= next_byte;
                        strobe <= 1'b1;
                        if (next_column == '0 && next_byte == '0) state <= ROW_CAPTURE;
                    end
                end
                default: state <= ROW_CAPTURE;
            endcase
        end
    end

    always_ff @(posedge clk_n) begin
        if (enable) data_q <= data_in;
    end

    always_comb begin
        ram_port = '0;
        ram_port.row = MAX_ROW_BITS'(row);
        ram_port.column = MAX_COL_BITS'(column);
        ram_port.byte_idx = MAX_BYTE_BITS'(byte_idx);
        ram_port.data = data_q;
        ram_port.strobe = strobe;
    end

    a_column_in_range: assert property (@(posedge clk_n) disable iff (reset)
        ram_port.strobe |-> (int'(ram_port.column) < PIXEL_WIDTH));

endmodule

//--- design/frame_buffer.sv
module frame_buffer import display_pkg::*; #(
    parameter int PIXEL_WIDTH,
    parameter int PIXEL_HEIGHT,
    parameter int BYTES_PER_PIXEL
) (
    input  logic                                   clk_n,
    input  ram_write_t                             wr,
    input  logic [bits_for(PIXEL_HEIGHT)-1:0]    rd_row,
    input  logic [bits_for(PIXEL_WIDTH)-1:0]     rd_column,
    input  logic [bits_for(BYTES_PER_PIXEL)-1:0] rd_byte,
    output logic [7:0]                             rd_data
);
    localparam int ROW_BITS = bits_for(PIXEL_HEIGHT);
    localparam int COL_BITS = bits_for(PIXEL_WIDTH);
    localparam int BYTE_BITS = bits_for(BYTES_PER_PIXEL);
    localparam int DEPTH = frame_bytes(PIXEL_WIDTH, PIXEL_HEIGHT, BYTES_PER_PIXEL);
    localparam int ADDR_BITS = bits_for(DEPTH);

    logic [7:0] mem [DEPTH];
    logic [31:0] wr_addr;
    logic [31:0] rd_addr;

    // pixels are contiguous, bytes of a pixel side by side.
    assign wr_addr = (32'(wr.row[ROW_BITS-1:0]) * PIXEL_WIDTH +
                      32'(wr.column[COL_BITS-1:0])) * BYTES_PER_PIXEL +
                     32'(wr.byte_idx[BYTE_BITS-1:0]);
    assign rd_addr = (32'(rd_row) * PIXEL_WIDTH + 32'(rd_column)) * BYTES_PER_PIXEL +
                     32'(rd_byte);

    always_ff @(posedge clk_n) begin
        if (wr.strobe) mem[wr_addr[ADDR_BITS-1:0]] <= wr.data;
        rd_data <= mem[rd_addr[ADDR_BITS-1:0]]; // one cycle read latency.
    end

    a_write_in_depth: assert property (@(posedge clk_n)
        wr.strobe |-> (wr_addr < 32'(DEPTH)));

endmodule

//--- design/scanout.sv
module scanout import display_pkg::*; #(
    parameter int PIXEL_WIDTH,
    parameter int PIXEL_HEIGHT,
    parameter int BYTES_PER_PIXEL
) (
    input  logic                                   clk_n,
    input  logic                                   reset,
    input  logic                                   start,
    output logic                                   busy,
    output logic [bits_for(PIXEL_HEIGHT)-1:0]    rd_row,
    output logic [bits_for(PIXEL_WIDTH)-1:0]     rd_column,
    output logic [bits_for(BYTES_PER_PIXEL)-1:0] rd_byte,
    input  logic [7:0]                             rd_data,
    output logic [PIX_PORT_BITS-1:0]               pix_data,
    output logic                                   pix_valid,
    input  logic                                   pix_ready,
    output logic                                   pix_last
);
    localparam int ROW_BITS = bits_for(PIXEL_HEIGHT);
    localparam int COL_BITS = bits_for(PIXEL_WIDTH);
    localparam int BYTE_BITS = bits_for(BYTES_PER_PIXEL);
    localparam int PHASE_BITS = bits_for(BYTES_PER_PIXEL + 1);

    scan_state_e state;
    logic [PHASE_BITS-1:0] phase; // read cycle within the pixel.
    logic at_last;
    pixel_t pixel_q;

    assign rd_byte = BYTE_BITS'(BYTES_PER_PIXEL - 1 - int'(phase)); // high byte first.
    assign at_last = (rd_row == ROW_BITS'(PIXEL_HEIGHT - 1)) &&
                     (rd_column == COL_BITS'(PIXEL_WIDTH - 1));

    assign busy = (state != SCAN_IDLE);
    assign pix_valid = (state == SCAN_PRESENT);
    assign pix_data = pixel_q.data;
    assign pix_last = pixel_q.last;

    always_ff @(posedge clk_n) begin
        if (reset) begin
            state <= SCAN_IDLE;
            rd_row <= '0;
            rd_column <= '0;
            phase <= '0;
            pixel_q <= '0;
        end else begin
            case (state)
                SCAN_IDLE: begin
                    if (start) begin
                        rd_row <= '0;
                        rd_column <= '0;
                        phase <= '0;
                        pixel_q.data <= '0;
                        state <= SCAN_READ;
                    end
                end
                SCAN_READ: begin
                    phase <= phase + 1'b1;
                    // data of the previous address arrives now.
                    if (phase != '0) pixel_q.data <= {pixel_q.data[PIX_PORT_BITS-9:0], rd_data};
                    if (phase == PHASE_BITS'(BYTES_PER_PIXEL)) begin
                        pixel_q.last <= at_last;
                        state <= SCAN_PRESENT;
                    end
                end
                SCAN_PRESENT: begin
                    if (pix_ready) begin
                        if (at_last) begin
                            state <= SCAN_IDLE;
                        end else begin
                            if (rd_column == COL_BITS'(PIXEL_WIDTH - 1)) begin
                                rd_column <= '0;
                                rd_row <= rd_row + 1'b1;
                            end else begin
                                rd_column <= rd_column + 1'b1;
                            end
                            phase <= '0;
                            pixel_q.data <= '0;
                            state <= SCAN_READ;
                        end
                    end
                end
                default: state <= SCAN_IDLE;
            endcase
        end
    end

    a_hold_under_stall: assert property (@(posedge clk_n) disable iff (reset)
        (pix_valid && !pix_ready) |=> (pix_valid && $stable(pix_data) && $stable(pix_last)));

endmodule

//--- design/display_ctrl.sv
`include "display_defaults.svh"

module display_ctrl import display_pkg::*; #(
    parameter int PIXEL_WIDTH = `DISPLAY_PIXEL_WIDTH,
    parameter int PIXEL_HEIGHT = `DISPLAY_PIXEL_HEIGHT,
    parameter int BYTES_PER_PIXEL = `DISPLAY_BYTES_PER_PIXEL
) (
    input  logic                     clk_n,
    input  logic                     reset,
    input  logic [7:0]               byte_data,
    input  logic                     byte_valid,
    output logic                     byte_ready,
    output logic [PIX_PORT_BITS-1:0] pix_data,
    output logic                     pix_valid,
    input  logic                     pix_ready,
    output logic                     pix_last
);
    logic writer_enable;
    logic writer_done;
    ram_write_t writer_port;
    ram_write_t ram_port;
    logic scan_start;
    logic scan_busy;
    logic [bits_for(PIXEL_HEIGHT)-1:0] rd_row;
    logic [bits_for(PIXEL_WIDTH)-1:0] rd_column;
    logic [bits_for(BYTES_PER_PIXEL)-1:0] rd_byte;
    logic [7:0] rd_data;

    cmd_decoder #(
        .PIXEL_WIDTH(PIXEL_WIDTH),
        .PIXEL_HEIGHT(PIXEL_HEIGHT),
        .BYTES_PER_PIXEL(BYTES_PER_PIXEL)
    ) cmd_decoder_inst (
        .clk_n(clk_n),
        .reset(reset),
        .byte_data(byte_data),
        .byte_valid(byte_valid),
        .byte_ready(byte_ready),
        .writer_enable(writer_enable),
        .writer_done(writer_done),
        .writer_port(writer_port),
        .ram_port(ram_port),
        .scan_start(scan_start),
        .scan_busy(scan_busy)
    );

    // the writer sees the command bytes directly, gated by the decoder.
    row_writer #(
        .PIXEL_WIDTH(PIXEL_WIDTH),
        .PIXEL_HEIGHT(PIXEL_HEIGHT),
        .BYTES_PER_PIXEL(BYTES_PER_PIXEL)
    ) row_writer_inst (
        .clk_n(clk_n),
        .reset(reset),
        .enable(writer_enable),
        .data_in(byte_data),
        .ram_port(writer_port),
        .done(writer_done)
    );

    frame_buffer #(
        .PIXEL_WIDTH(PIXEL_WIDTH),
        .PIXEL_HEIGHT(PIXEL_HEIGHT),
        .BYTES_PER_PIXEL(BYTES_PER_PIXEL)
    ) frame_buffer_inst (
        .clk_n(clk_n),
        .wr(ram_port),
        .rd_row(rd_row),
        .rd_column(rd_column),
        .rd_byte(rd_byte),
        .rd_data(rd_data)
    );

    scanout #(
        .PIXEL_WIDTH(PIXEL_WIDTH),
        .PIXEL_HEIGHT(PIXEL_HEIGHT),
        .BYTES_PER_PIXEL(BYTES_PER_PIXEL)
    ) scanout_inst (
        .clk_n(clk_n),
        .reset(reset),
        .start(scan_start),
        .busy(scan_busy),
        .rd_row(rd_row),
        .rd_column(rd_column),
        .rd_byte(rd_byte),
        .rd_data(rd_data),
        .pix_data(pix_data),
        .pix_valid(pix_valid),
        .pix_ready(pix_ready),
        .pix_last(pix_last)
    );

endmodule

//--- bench/display_ctrl_tb.sv
`include "display_defaults.svh"

module display_ctrl_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int PIXEL_WIDTH = `DISPLAY_PIXEL_WIDTH;
    localparam int PIXEL_HEIGHT = `DISPLAY_PIXEL_HEIGHT;
    localparam int BYTES_PER_PIXEL = `DISPLAY_BYTES_PER_PIXEL;
    localparam int FRAME_PIXELS = PIXEL_WIDTH * PIXEL_HEIGHT;
    localparam int FRAME_BYTES = FRAME_PIXELS * BYTES_PER_PIXEL;
    localparam int NUM_COMMANDS = PIXEL_HEIGHT + 10;
    localparam int WATCHDOG_CYCLES = NUM_COMMANDS * FRAME_BYTES * 20 + 1000;
    localparam logic [7:0] OP_WRITE_ROW = 8'd1;
    localparam logic [7:0] OP_FILL = 8'd2;
    localparam logic [7:0] OP_SCAN = 8'd3;

    logic clk_n;
    logic reset;
    logic [7:0] byte_data;
    logic byte_valid;
    logic byte_ready;
    logic [31:0] pix_data;
    logic pix_valid;
    logic pix_ready;
    logic pix_last;

    logic [31:0] lfsr_state = 32'd68788;
    logic [7:0] model []; // frame contents, row-major, byte index innermost.
    int scan_count = FRAME_PIXELS; // pixels seen in the current scan.
    string test_name = "reset";

    display_ctrl #(
        .PIXEL_WIDTH(PIXEL_WIDTH),
        .PIXEL_HEIGHT(PIXEL_HEIGHT),
        .BYTES_PER_PIXEL(BYTES_PER_PIXEL)
    ) display_ctrl_inst (
        .clk_n(clk_n),
        .reset(reset),
        .byte_data(byte_data),
        .byte_valid(byte_valid),
        .byte_ready(byte_ready),
        .pix_data(pix_data),
        .pix_valid(pix_valid),
        .pix_ready(pix_ready),
        .pix_last(pix_last)
    );

    initial begin
        clk_n = 1'b0;
        forever #5 clk_n = ~clk_n;
    end

    // taps 32, 22, 2, 1.
    function automatic logic next_bit();
        logic feedback;
        feedback = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
        lfsr_state = {lfsr_state[30:0], feedback};
        return feedback;
    endfunction

    function automatic logic [7:0] random_byte();
        logic [7:0] value;
        value = '0;
        for (int i = 0; i < 8; i++) value = {value[6:0], next_bit()};
        return value;
    endfunction

    function automatic int model_index(input int row, input int column, input int byte_idx);
        return (row * PIXEL_WIDTH + column) * BYTES_PER_PIXEL + byte_idx;
    endfunction

    // most significant byte is the highest byte index.
    function automatic logic [31:0] expected_pixel(input int row, input int column);
        logic [31:0] word;
        word = '0;
        for (int b = BYTES_PER_PIXEL - 1; b >= 0; b--) begin
            word = {word[23:0], model[model_index(row, column, b)]};
        end
        return word;
    endfunction

    task automatic abort_run();
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            $display("[ERROR] %s: expected %h, actual %h", name, expected, actual);
            abort_run();
        end
    endtask

    // entered and left on a falling edge, valid dropped once the byte is taken.
    task automatic send_byte(input logic [7:0] value);
        while (!byte_ready) @(negedge clk_n);
        byte_data = value;
        byte_valid = 1'b1;
        @(negedge clk_n);
        byte_valid = 1'b0;
    endtask

    task automatic fill_frame(input logic [7:0] value);
        send_byte(OP_FILL);
        send_byte(value);
        for (int i = 0; i < FRAME_BYTES; i++) model[i] = value;
    endtask

    task automatic write_row(input logic [7:0] row_byte);
        int row;
        logic [7:0] value;
        row = int'(row_byte) % PIXEL_HEIGHT;
        send_byte(OP_WRITE_ROW);
        send_byte(row_byte);
        for (int k = 0; k < PIXEL_WIDTH * BYTES_PER_PIXEL; k++) begin
            value = random_byte();
            // columns and bytes arrive from the top down.
            model[model_index(row, PIXEL_WIDTH - 1 - k / BYTES_PER_PIXEL,
                              BYTES_PER_PIXEL - 1 - k % BYTES_PER_PIXEL)] = value;
            send_byte(value);
        end
    endtask

    task automatic run_scan(input logic random_ready);
        scan_count = 0;
        send_byte(OP_SCAN);
        while (scan_count < FRAME_PIXELS) begin
            pix_ready = random_ready ? next_bit() : 1'b1;
            @(negedge clk_n);
        end
        pix_ready = 1'b1;
    endtask

    always @(posedge clk_n) begin
        if (!reset && pix_valid && pix_ready) begin
            if (scan_count >= FRAME_PIXELS) begin
                $display("a pixel came out while no scan was expected");
                abort_run();
            end else begin
                check_value({test_name, " pixel"},
                            expected_pixel(scan_count / PIXEL_WIDTH, scan_count % PIXEL_WIDTH),
                            pix_data);
                check_value({test_name, " last"}, 32'(scan_count == FRAME_PIXELS - 1),
                            32'(pix_last));
                scan_count = scan_count + 1;
            end
        end
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk_n);
        $display("timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
        abort_run();
    end

    initial begin
        reset = 1'b1;
        byte_data = '0;
        byte_valid = 1'b0;
        pix_ready = 1'b1;
        model = new[FRAME_BYTES];
        repeat (5) @(posedge clk_n);
        @(negedge clk_n);
        reset = 1'b0;
        @(negedge clk_n);

        check_value("reset ready", 32'd1, 32'(byte_ready));
        check_value("reset valid", 32'd0, 32'(pix_valid));

        test_name = "fill";
        fill_frame(random_byte());
        run_scan(1'b0);

        test_name = "row writes";
        for (int r = 0; r < PIXEL_HEIGHT; r++) write_row(8'(r));
        repeat (2) write_row(8'(PIXEL_HEIGHT + int'(random_byte()) % (256 - PIXEL_HEIGHT)));
        run_scan(1'b0);

        test_name = "random ready";
        run_scan(1'b1);

        test_name = "unknown opcode";
        send_byte(8'h00);
        send_byte(8'hc3);
        check_value("unknown opcode ready", 32'd1, 32'(byte_ready)); // back in idle.
        write_row(random_byte());
        run_scan(1'b0);

        $display("PASS: all tests");
        $finish;
    end

endmodule

//--- sources.f
+incdir+include
design/display_pkg.sv
design/cmd_decoder.sv
design/row_writer.sv
design/frame_buffer.sv
design/scanout.sv
design/display_ctrl.sv
bench/display_ctrl_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
rm -f build.log sim.log
verilator --binary --timing --assert -f sources.f --top-module display_ctrl_tb \
    -o display_sim > build.log 2>&1 \
    || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/display_sim > sim.log 2>&1 || true
cat sim.log
grep -q "FAIL: see errors above" sim.log && { echo "simulation failed"; exit 1; }
grep -q "PASS: all tests" sim.log || { echo "simulation ended without a result"; exit 1; }
echo "simulation passed"
exit 0
